// ==== project.f ====
src/sata_dma_pkg.sv
src/sata_dma_interface.sv
src/dma_write_fifo.sv
src/dma_read_fifo.sv
src/sata_dma_top.sv
testbench/sata_dma_props.sv
testbench/tb_sata_dma.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SATA DMA testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_sata_dma \
    -Mdir obj_dir -f project.f; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_sata_dma)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" <<< "$output"; then
  exit 0
fi
exit 1

// ==== testbench/tb_sata_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sata_dma;

  import sata_dma_pkg::*;

  localparam int wait_limit = 5000;

  logic          clk;
  logic          rst_n;
  logic          enable;
  logic          write_enable;
  dma_addr_t     write_addr;
  xfer_count_t   write_count;
  logic          write_finished;
  logic          read_enable;
  dma_addr_t     read_addr;
  xfer_count_t   read_count;
  logic          read_busy;
  dword_t        host_wr_data;
  logic          host_wr_strobe;
  logic          host_wr_full;
  dword_t        host_rd_data;
  logic          host_rd_empty;
  logic          host_rd_strobe;
  sata_cmd_t     sata_command;
  lba_t          sata_lba;
  sector_count_t sata_sector_count;
  logic          sata_execute_command_stb;
  logic          sata_busy;
  dword_t        sata_wr_data;
  logic          sata_wr_empty;
  logic          sata_wr_strobe;
  dword_t        sata_rd_data;
  logic          sata_rd_strobe;
  logic          sata_rd_full;

  int            errors;
  int            timeouts;
  int            stalls;
  logic [31:0]   lfsr;
  // Dwords in flight between host and controller, oldest first
  dword_t        scoreboard[$];

  sata_dma_top dut (.*);

  bind sata_dma_interface sata_dma_props u_props (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .sata_execute_command_stb (sata_execute_command_stb),
    .sata_busy                (sata_busy),
    .write_finished           (write_finished),
    .read_busy                (read_busy),
    .write_window             (write_window),
    .state                    (state)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic random_word(output dword_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic expect_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got == exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_progress(input int n, input string what);
    assert (n < wait_limit) else begin
      $display("Timed out waiting for %s", what);
      timeouts++;
    end
  endtask

  task automatic expect_idle_controls();
    expect_value("sata_execute_command_stb", sata_execute_command_stb, 0);
    expect_value("write_finished", write_finished, 0);
    expect_value("read_busy", read_busy, 0);
    expect_value("sata_command", sata_command, 0);
    expect_value("sata_lba", sata_lba, 0);
    expect_value("sata_sector_count", sata_sector_count, 0);
    // Window closed, so the controller sees nothing
    expect_value("sata_wr_empty", sata_wr_empty, 1);
  endtask

  // Host pushes the payload, then zero padding up to whole sectors
  task automatic push_host_words(input int payload, input int total);
    int     sent;
    int     n;
    dword_t w;
    sent = 0;
    n    = 0;
    while (sent < total && n < wait_limit) begin
      @(negedge clk);
      host_wr_strobe = 1'b0;
      if (host_wr_full) begin
        stalls++;
        n++;
      end else begin
        if (sent < payload) random_word(w);
        else w = '0;
        host_wr_data   = w;
        host_wr_strobe = 1'b1;
        scoreboard.push_back(w);
        sent++;
        n = 0;
      end
    end
    @(negedge clk);
    host_wr_strobe = 1'b0;
    expect_progress(n, "room in the write FIFO");
  endtask

  task automatic pop_host_words(input int total);
    int got;
    int n;
    got = 0;
    n   = 0;
    while (got < total && n < wait_limit) begin
      @(negedge clk);
      host_rd_strobe = !host_rd_empty;
      if (!host_rd_empty) begin
        expect_value("host_rd_data", host_rd_data, scoreboard.pop_front());
        got++;
        n = 0;
      end else begin
        n++;
      end
    end
    @(negedge clk);
    host_rd_strobe = 1'b0;
    expect_progress(n, "data in the read FIFO");
  endtask

  // SATA drive model for one command
  task automatic controller_model(input logic is_write, input int exp_cmd,
                                  input lba_t exp_lba, input int exp_sectors);
    int     n;
    int     moved;
    int     target;
    logic   pace;
    dword_t w;
    n = 0;
    while (!sata_execute_command_stb && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    expect_progress(n, "the execute strobe");
    if (n >= wait_limit) return;
    expect_value("sata_command", sata_command, exp_cmd);
    expect_value("sata_lba", sata_lba, exp_lba);
    expect_value("sata_sector_count", sata_sector_count, exp_sectors);
    if (!is_write) expect_value("read_busy", read_busy, 1);
    target = exp_sectors * 128;
    // Busy rises once the strobe has gone
    @(negedge clk);
    sata_busy = 1'b1;
    moved     = 0;
    n         = 0;
    pace      = 1'b1;
    while (moved < target && n < wait_limit) begin
      if (is_write) begin
        // Drive pulls on alternate cycles, slower than the host pushes
        sata_wr_strobe = pace && !sata_wr_empty;
        if (sata_wr_strobe) begin
          expect_value("sata_wr_data", sata_wr_data, scoreboard.pop_front());
          moved++;
        end
        pace = !pace;
      end else begin
        sata_rd_strobe = !sata_rd_full;
        if (!sata_rd_full) begin
          random_word(w);
          sata_rd_data = w;
          scoreboard.push_back(w);
          moved++;
        end
      end
      n = (sata_wr_strobe || sata_rd_strobe) ? 0 : n + 1;
      @(negedge clk);
    end
    sata_wr_strobe = 1'b0;
    sata_rd_strobe = 1'b0;
    sata_busy      = 1'b0;
    expect_progress(n, "the controller data stream");
  endtask

  task automatic write_transfer(input dma_addr_t addr, input int count);
    int   sectors;
    int   total;
    int   chunk;
    int   n;
    lba_t lba;
    scoreboard.delete();
    sectors = (count + 127) / 128;
    total   = sectors * 128;
    lba     = lba_t'(addr >> 7);
    @(negedge clk);
    write_addr   = addr;
    write_count  = xfer_count_t'(count);
    write_enable = 1'b1;
    fork
      push_host_words(count, total);
      while (sectors > 0) begin
        chunk = (sectors > max_sector_count) ? max_sector_count : sectors;
        controller_model(1'b1, cmd_write_dma_ext, lba, chunk);
        lba     = lba + lba_t'(chunk);
        sectors = sectors - chunk;
      end
    join
    n = 0;
    while (!write_finished && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    expect_progress(n, "write_finished");
    // Completion holds while the request stays up
    repeat (4) begin
      @(negedge clk);
      expect_value("write_finished", write_finished, 1);
    end
    write_enable = 1'b0;
    @(negedge clk);
    expect_value("write_finished", write_finished, 0);
  endtask

  task automatic read_transfer(input dma_addr_t addr, input int count);
    int   sectors;
    int   total;
    int   chunk;
    int   n;
    lba_t lba;
    scoreboard.delete();
    sectors = (count + 127) / 128;
    total   = sectors * 128;
    lba     = lba_t'(addr >> 7);
    @(negedge clk);
    read_addr   = addr;
    read_count  = xfer_count_t'(count);
    read_enable = 1'b1;
    fork
      pop_host_words(total);
      while (sectors > 0) begin
        chunk = (sectors > max_sector_count) ? max_sector_count : sectors;
        controller_model(1'b0, cmd_read_dma_ext, lba, chunk);
        lba     = lba + lba_t'(chunk);
        sectors = sectors - chunk;
      end
    join
    n = 0;
    while (read_busy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    expect_progress(n, "read_busy to fall");
    read_enable = 1'b0;
    @(negedge clk);
  endtask

  task automatic enable_drop_test();
    int n;
    scoreboard.delete();
    // Prefill the write FIFO while the window is still shut
    push_host_words(12, 12);
    write_addr   = 64'h4000;
    write_count  = xfer_count_t'(512);
    write_enable = 1'b1;
    n = 0;
    while (!sata_execute_command_stb && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    expect_progress(n, "the execute strobe");
    @(negedge clk);
    sata_busy = 1'b1;
    repeat (6) begin
      sata_wr_strobe = !sata_wr_empty;
      if (!sata_wr_empty) begin
        expect_value("sata_wr_data", sata_wr_data, scoreboard.pop_front());
      end
      @(negedge clk);
    end
    sata_wr_strobe = 1'b0;
    enable         = 1'b0;
    @(negedge clk);
    expect_idle_controls();
    enable       = 1'b1;
    write_enable = 1'b0;
    sata_busy    = 1'b0;
    read_transfer(64'h8000, 300);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    enable         = 1'b1;
    write_enable   = 1'b0;
    write_addr     = '0;
    write_count    = '0;
    read_enable    = 1'b0;
    read_addr      = '0;
    read_count     = '0;
    host_wr_data   = '0;
    host_wr_strobe = 1'b0;
    host_rd_strobe = 1'b0;
    sata_busy      = 1'b0;
    sata_wr_strobe = 1'b0;
    sata_rd_data   = '0;
    sata_rd_strobe = 1'b0;
    errors         = 0;
    timeouts       = 0;
    stalls         = 0;
    lfsr           = 32'd58;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    expect_idle_controls();
    expect_value("host_wr_full", host_wr_full, 0);
    expect_value("host_rd_empty", host_rd_empty, 1);
    expect_value("sata_rd_full", sata_rd_full, 0);

    write_transfer(64'h1000, 200);

    stalls = 0;
    write_transfer(64'h2380, 700);
    assert (stalls > 0) else begin
      $display("Host never saw host_wr_full during the long write");
      errors++;
    end

    read_transfer(64'h5000, 600);
    enable_drop_test();

    $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Hard stop in case a wait chain never ends
  initial begin
    #1_000_000;
    $display("Simulation limit reached before the tests finished");
    $display("Summary: %0d check errors, %0d timeouts", errors, timeouts + 1);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/sata_dma_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module sata_dma_props (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       sata_execute_command_stb,
  input  wire                       sata_busy,
  input  wire                       write_finished,
  input  wire                       read_busy,
  input  wire                       write_window,
  input  sata_dma_pkg::seq_state_t  state
);

  import sata_dma_pkg::*;

  // Execute is a single-cycle pulse
  stb_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    sata_execute_command_stb |=> !sata_execute_command_stb)
    else $error("execute strobe lasted two cycles");

  stb_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(sata_execute_command_stb && sata_busy))
    else $error("execute strobe while the drive is busy");

  status_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(write_finished && read_busy))
    else $error("write_finished and read_busy both high");

  // Window belongs to the write data phase only
  window_in_data: assert property (@(posedge clk) disable iff (!rst_n)
    (state != write_data) |-> !write_window)
    else $error("write window open outside write data");

endmodule

`default_nettype wire

// ==== src/sata_dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sata_dma_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          enable,
  // Host request and status
  input  wire                          write_enable,
  input  sata_dma_pkg::dma_addr_t      write_addr,
  input  sata_dma_pkg::xfer_count_t    write_count,
  output logic                         write_finished,
  input  wire                          read_enable,
  input  sata_dma_pkg::dma_addr_t      read_addr,
  input  sata_dma_pkg::xfer_count_t    read_count,
  output logic                         read_busy,
  // Host data
  input  sata_dma_pkg::dword_t         host_wr_data,
  input  wire                          host_wr_strobe,
  output logic                         host_wr_full,
  output sata_dma_pkg::dword_t         host_rd_data,
  output logic                         host_rd_empty,
  input  wire                          host_rd_strobe,
  // SATA command
  output sata_dma_pkg::sata_cmd_t      sata_command,
  output sata_dma_pkg::lba_t           sata_lba,
  output sata_dma_pkg::sector_count_t  sata_sector_count,
  output logic                         sata_execute_command_stb,
  input  wire                          sata_busy,
  // SATA data
  output sata_dma_pkg::dword_t         sata_wr_data,
  output logic                         sata_wr_empty,
  input  wire                          sata_wr_strobe,
  input  sata_dma_pkg::dword_t         sata_rd_data,
  input  wire                          sata_rd_strobe,
  output logic                         sata_rd_full
);

  logic wr_pop;
  logic rd_push;
  logic write_window;

  sata_dma_interface u_sequencer (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .enable                   (enable),
    .sata_command             (sata_command),
    .sata_execute_command_stb (sata_execute_command_stb),
    .sata_lba                 (sata_lba),
    .sata_sector_count        (sata_sector_count),
    .sata_busy                (sata_busy),
    .write_enable             (write_enable),
    .write_addr               (write_addr),
    .write_count              (write_count),
    .write_finished           (write_finished),
    .read_enable              (read_enable),
    .read_addr                (read_addr),
    .read_count               (read_count),
    .read_busy                (read_busy),
    .wr_pop                   (wr_pop),
    .rd_push                  (rd_push),
    .write_window             (write_window)
  );

  dma_write_fifo u_write_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_wr_data   (host_wr_data),
    .host_wr_strobe (host_wr_strobe),
    .host_wr_full   (host_wr_full),
    .write_window   (write_window),
    .sata_wr_data   (sata_wr_data),
    .sata_wr_empty  (sata_wr_empty),
    .sata_wr_strobe (sata_wr_strobe),
    .wr_pop         (wr_pop)
  );

  dma_read_fifo u_read_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .sata_rd_data   (sata_rd_data),
    .sata_rd_strobe (sata_rd_strobe),
    .sata_rd_full   (sata_rd_full),
    .rd_push        (rd_push),
    .host_rd_data   (host_rd_data),
    .host_rd_empty  (host_rd_empty),
    .host_rd_strobe (host_rd_strobe)
  );

endmodule

`default_nettype wire

// ==== src/dma_read_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_read_fifo (
  input  wire                   clk,
  input  wire                   rst_n,
  // Controller side
  input  sata_dma_pkg::dword_t  sata_rd_data,
  input  wire                   sata_rd_strobe,
  output logic                  sata_rd_full,
  output logic                  rd_push,
  // Host side
  output sata_dma_pkg::dword_t  host_rd_data,
  output logic                  host_rd_empty,
  input  wire                   host_rd_strobe
);

  import sata_dma_pkg::*;

  dword_t                     mem [2**fifo_depth_log2];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;
  logic [fifo_depth_log2:0]   occupancy;

  logic pop;

  assign sata_rd_full  = occupancy[fifo_depth_log2];
  // Sequencer counts only words that actually land in the buffer
  assign rd_push       = sata_rd_strobe && !sata_rd_full;

  assign host_rd_empty = (occupancy == '0);
  assign pop           = host_rd_strobe && !host_rd_empty;
  assign host_rd_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rd_push) begin
      mem[wr_ptr] <= sata_rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (rd_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rd_push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/dma_write_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_write_fifo (
  input  wire                   clk,
  input  wire                   rst_n,
  // Host side
  input  sata_dma_pkg::dword_t  host_wr_data,
  input  wire                   host_wr_strobe,
  output logic                  host_wr_full,
  // Controller side
  input  wire                   write_window,
  output sata_dma_pkg::dword_t  sata_wr_data,
  output logic                  sata_wr_empty,
  input  wire                   sata_wr_strobe,
  output logic                  wr_pop
);

  import sata_dma_pkg::*;

  dword_t                     mem [2**fifo_depth_log2];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from an empty one
  logic [fifo_depth_log2:0]   occupancy;

  logic push;
  logic available;

  assign host_wr_full = occupancy[fifo_depth_log2];
  assign push         = host_wr_strobe && !host_wr_full;

  // Controller only sees data while the sequencer has the window open
  assign available     = write_window && (occupancy != '0);
  assign sata_wr_empty = !available;
  assign wr_pop        = sata_wr_strobe && available;

  assign sata_wr_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= host_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (wr_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      case ({push, wr_pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/sata_dma_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module sata_dma_interface (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          enable,
  // SATA controller command side
  output sata_dma_pkg::sata_cmd_t      sata_command,
  output logic                         sata_execute_command_stb,
  output sata_dma_pkg::lba_t           sata_lba,
  output sata_dma_pkg::sector_count_t  sata_sector_count,
  input  wire                          sata_busy,
  // Host write request
  input  wire                          write_enable,
  input  sata_dma_pkg::dma_addr_t      write_addr,
  input  sata_dma_pkg::xfer_count_t    write_count,
  output logic                         write_finished,
  // Host read request
  input  wire                          read_enable,
  input  sata_dma_pkg::dma_addr_t      read_addr,
  input  sata_dma_pkg::xfer_count_t    read_count,
  output logic                         read_busy,
  // FIFO handshakes
  input  wire                          wr_pop,
  input  wire                          rd_push,
  output logic                         write_window
);

  import sata_dma_pkg::*;

  seq_state_t    state;

  // Sectors still to be issued after the current command
  xfer_count_t   remaining_sectors;
  // Dwords moved for the current command
  xfer_count_t   dword_count;
  // LBA of the next command to issue
  lba_t          next_lba;

  sector_count_t chunk_sectors;
  xfer_count_t   dword_target;
  logic          data_complete;

  // Round the dword length up to whole sectors
  function automatic xfer_count_t sectors_of(input xfer_count_t count);
    xfer_count_t whole;
    xfer_count_t partial;
    whole   = count >> dwords_per_sector_log2;
    partial = xfer_count_t'(|count[dwords_per_sector_log2-1:0]);
    return whole + partial;
  endfunction

  // Dword address to sector address
  function automatic lba_t lba_of(input dma_addr_t addr);
    dma_addr_t shifted;
    shifted = addr >> dwords_per_sector_log2;
    return lba_t'(shifted);
  endfunction

  // Next command takes at most max_sector_count sectors
  assign chunk_sectors =
    (remaining_sectors >= xfer_count_t'(max_sector_count)) ?
      sector_count_t'(max_sector_count) : sector_count_t'(remaining_sectors);

  assign dword_target  = xfer_count_t'(sata_sector_count) << dwords_per_sector_log2;

  // Command share moved and the drive has let go of busy
  assign data_complete = (dword_count >= dword_target) && !sata_busy;

  // Window shuts as soon as the command's share has been pulled
  assign write_window   = (state == write_data) && (dword_count < dword_target);

  assign write_finished = (state == write_done);

  always_comb begin
    case (state)
      idle:                               read_busy = enable && read_enable && !write_enable;
      read_setup, read_command, read_data: read_busy = 1'b1;
      default:                            read_busy = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || !enable) begin
      state                    <= idle;
      sata_command             <= '0;
      sata_lba                 <= '0;
      sata_sector_count        <= '0;
      sata_execute_command_stb <= 1'b0;
      remaining_sectors        <= '0;
      dword_count              <= '0;
      next_lba                 <= '0;
    end else begin
      sata_execute_command_stb <= 1'b0;
      case (state)
        idle: begin
          // Write takes priority when both requests are up
          if (write_enable) begin
            remaining_sectors <= sectors_of(write_count);
            next_lba          <= lba_of(write_addr);
            state             <= write_setup;
          end else if (read_enable) begin
            remaining_sectors <= sectors_of(read_count);
            next_lba          <= lba_of(read_addr);
            state             <= read_setup;
          end
        end

        write_setup, read_setup: begin
          if (!sata_busy) begin
            sata_lba          <= next_lba;
            sata_sector_count <= chunk_sectors;
            next_lba          <= next_lba + lba_t'(chunk_sectors);
            remaining_sectors <= remaining_sectors - xfer_count_t'(chunk_sectors);
            dword_count       <= '0;
            if (state == write_setup) begin
              sata_command <= sata_cmd_t'(cmd_write_dma_ext);
              state        <= write_command;
            end else begin
              sata_command <= sata_cmd_t'(cmd_read_dma_ext);
              state        <= read_command;
            end
          end
        end

        write_command: begin
          sata_execute_command_stb <= 1'b1;
          state                    <= write_data;
        end

        read_command: begin
          sata_execute_command_stb <= 1'b1;
          state                    <= read_data;
        end

        write_data: begin
          if (wr_pop) begin
            dword_count <= dword_count + 1'b1;
          end
          if (data_complete) begin
            state <= (remaining_sectors != '0) ? write_setup : write_done;
          end
        end

        read_data: begin
          if (rd_push) begin
            dword_count <= dword_count + 1'b1;
          end
          if (data_complete) begin
            state <= (remaining_sectors != '0) ? read_setup : read_done;
          end
        end

        // Hold completion until the host drops its request
        write_done: begin
          if (!write_enable) begin
            state <= idle;
          end
        end

        read_done: begin
          if (!read_enable) begin
            state <= idle;
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/sata_dma_pkg.sv ====
`default_nettype none

package sata_dma_pkg;

  // Data and address widths
  typedef logic [31:0] dword_t;
  typedef logic [63:0] dma_addr_t;
  typedef logic [23:0] xfer_count_t;

  // SATA command fields
  typedef logic [47:0] lba_t;
  typedef logic [15:0] sector_count_t;
  typedef logic [7:0]  sata_cmd_t;

  // One sector is 512 bytes, i.e. 128 dwords
  localparam int dwords_per_sector_log2 = 7;

  // Largest single command, in sectors
  localparam int max_sector_count = 4;

  // ATA DMA extended commands
  localparam int cmd_write_dma_ext = 'h35;
  localparam int cmd_read_dma_ext  = 'h25;

  // Both FIFOs hold 16 dwords
  localparam int fifo_depth_log2 = 4;

  typedef enum logic [3:0] {
    idle,
    write_setup,
    write_command,
    write_data,
    write_done,
    read_setup,
    read_command,
    read_data,
    read_done
  } seq_state_t;

endpackage

`default_nettype wire
